//--- sim.f
logic/lc4_pkg.sv
logic/lc4_decoder.sv
logic/lc4_regfile.sv
logic/lc4_issue.sv
logic/lc4_bypass.sv
logic/lc4_alu.sv
logic/lc4_core.sv
bench/tb_lc4_model.sv
bench/tb_lc4_core.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module tb_lc4_core -o tb_lc4_core
	./obj_dir/tb_lc4_core | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/tb_lc4_core.sv
module tb_lc4_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PROG_LEN     = 256;
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    // four cycles per instruction leaves room for fill and switch bubbles
    localparam int WATCHDOG_NS  = PROG_LEN * CLK_PERIOD * 4;

    logic              gwe;
    logic              i_arst_n;
    lc4_pkg::word_t    i_insn_a;
    lc4_pkg::word_t    i_insn_b;
    lc4_pkg::word_t    o_fetch_pc;
    logic              o_wb_valid_a;
    lc4_pkg::word_t    o_wb_pc_a;
    lc4_pkg::word_t    o_wb_insn_a;
    logic              o_wb_we_a;
    lc4_pkg::reg_idx_t o_wb_rd_a;
    lc4_pkg::word_t    o_wb_data_a;
    logic              o_wb_valid_b;
    lc4_pkg::word_t    o_wb_pc_b;
    lc4_pkg::word_t    o_wb_insn_b;
    logic              o_wb_we_b;
    lc4_pkg::reg_idx_t o_wb_rd_b;
    lc4_pkg::word_t    o_wb_data_b;
    int                failures = 0;

    lc4_core #(.P_RESET_PC(lc4_pkg::RESET_PC)) dut (
        .gwe, .i_arst_n, .i_insn_a, .i_insn_b, .o_fetch_pc,
        .o_wb_valid_a, .o_wb_pc_a, .o_wb_insn_a, .o_wb_we_a, .o_wb_rd_a, .o_wb_data_a,
        .o_wb_valid_b, .o_wb_pc_b, .o_wb_insn_b, .o_wb_we_b, .o_wb_rd_b, .o_wb_data_b
    );

    tb_lc4_model u_model ();

    initial begin
        gwe = 1'b0;
        forever #(CLK_PERIOD / 2) gwe = ~gwe;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: program did not retire within %0d ns", WATCHDOG_NS);
        $display("Something failed");
        $fatal(1, "timeout");
    end

    // instruction memory, word pair at the fetch PC
    always @(negedge gwe) begin
        i_insn_a = u_model.fetch_word(o_fetch_pc);
        i_insn_b = u_model.fetch_word(o_fetch_pc + 16'd1);
    end

    task automatic stop_on_mismatch();
        failures++;
        $display("Something failed");
        $fatal(1, "check failed");
    endtask

    task automatic check_retire(input string pipe, input lc4_pkg::word_t pc,
                                input lc4_pkg::word_t insn, input logic we,
                                input lc4_pkg::reg_idx_t rd, input lc4_pkg::word_t data);
        lc4_pkg::word_t    exp_pc;
        lc4_pkg::word_t    exp_insn;
        lc4_pkg::word_t    exp_data;
        logic              exp_we;
        lc4_pkg::reg_idx_t exp_rd;
        bit                ok;
        u_model.retire_next(exp_pc, exp_insn, exp_we, exp_rd, exp_data);
        u_model.check_word({"wb pc ", pipe}, pc, exp_pc, ok);
        if (!ok) stop_on_mismatch();
        u_model.check_word({"wb insn ", pipe}, insn, exp_insn, ok);
        if (!ok) stop_on_mismatch();
        u_model.check_bit({"wb we ", pipe}, we, exp_we, ok);
        if (!ok) stop_on_mismatch();
        u_model.check_word({"wb data ", pipe}, data, exp_data, ok);
        if (!ok) stop_on_mismatch();
        if (exp_we) begin
            u_model.check_reg({"wb rd ", pipe}, rd, exp_rd, ok);
            if (!ok) stop_on_mismatch();
        end
    endtask

    task automatic check_cycle();
        bit ok;
        // the opening CONST block retires as full pairs
        if (u_model.next_idx < 32 && (u_model.next_idx > 0 || o_wb_valid_a || o_wb_valid_b)) begin
            u_model.check_bit("const block valid a", o_wb_valid_a, 1'b1, ok);
            if (!ok) stop_on_mismatch();
            u_model.check_bit("const block valid b", o_wb_valid_b, 1'b1, ok);
            if (!ok) stop_on_mismatch();
        end
        if (o_wb_valid_a) check_retire("a", o_wb_pc_a, o_wb_insn_a, o_wb_we_a, o_wb_rd_a,
                                       o_wb_data_a);
        if (o_wb_valid_b && u_model.next_idx < PROG_LEN) begin
            check_retire("b", o_wb_pc_b, o_wb_insn_b, o_wb_we_b, o_wb_rd_b, o_wb_data_b);
        end
        if (o_wb_valid_a && o_wb_valid_b) begin
            u_model.check_bit("dependent pair retired together",
                              u_model.depends_on(o_wb_insn_a, o_wb_insn_b), 1'b0, ok);
            if (!ok) stop_on_mismatch();
        end
    endtask

    initial begin
        bit ok;
        i_arst_n = 1'b0;
        i_insn_a = '0;
        i_insn_b = '0;
        u_model.gen_program();
        repeat (RESET_CYCLES) begin
            @(negedge gwe);
            u_model.check_word("fetch pc in reset", o_fetch_pc, lc4_pkg::RESET_PC, ok);
            if (!ok) stop_on_mismatch();
            u_model.check_bit("wb valid a in reset", o_wb_valid_a, 1'b0, ok);
            if (!ok) stop_on_mismatch();
            u_model.check_bit("wb valid b in reset", o_wb_valid_b, 1'b0, ok);
            if (!ok) stop_on_mismatch();
        end
        i_arst_n = 1'b1;
        while (u_model.next_idx < PROG_LEN) begin
            @(negedge gwe);
            check_cycle();
        end
        if (failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- bench/tb_lc4_model.sv
module tb_lc4_model;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PROG_LEN = 256;
    localparam int K_NOP    = 0;
    localparam int K_BIN    = 1;
    localparam int K_UNARY  = 2;
    localparam int K_CONST  = 3;

    lc4_pkg::word_t prog [PROG_LEN];
    lc4_pkg::word_t arch_regs [lc4_pkg::NUM_REGS];
    logic [31:0]    lcg_state = 32'h292e_8466;
    int             next_idx = 0;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // how an instruction uses the register file
    function automatic int kind_of(input lc4_pkg::insn_u u);
        case (u.rr.opcode)
            lc4_pkg::OP_CONST: return K_CONST;
            lc4_pkg::OP_ARITH: begin
                return (u.rr.subop inside {lc4_pkg::ADD, lc4_pkg::MUL, lc4_pkg::SUB}) ?
                       K_BIN : K_NOP;
            end
            lc4_pkg::OP_LOGIC: begin
                if (u.rr.subop == lc4_pkg::NOT) return K_UNARY;
                return (u.rr.subop inside {lc4_pkg::AND, lc4_pkg::OR, lc4_pkg::XOR}) ?
                       K_BIN : K_NOP;
            end
            default: return K_NOP;
        endcase
    endfunction

    // younger reads the register that older writes
    function automatic bit depends_on(input lc4_pkg::insn_u older,
                                      input lc4_pkg::insn_u younger);
        int yk;
        yk = kind_of(younger);
        if (kind_of(older) == K_NOP || yk == K_NOP || yk == K_CONST) return 1'b0;
        return (younger.rr.rs == older.ci.rd) ||
               (yk == K_BIN && younger.rr.rt == older.ci.rd);
    endfunction

    function automatic lc4_pkg::word_t fetch_word(input lc4_pkg::word_t addr);
        lc4_pkg::word_t off;
        off = addr - lc4_pkg::RESET_PC;
        if (off < PROG_LEN) return prog[off[7:0]];
        // past the program: opcode 0000 no-ops tagged with their address
        return {4'b0000, addr[11:0] ^ {8'h00, addr[15:12]}};
    endfunction

    task automatic gen_program();
        lc4_pkg::insn_u u;
        lc4_pkg::insn_u src;
        logic [31:0]    r;
        for (int i = 0; i < lc4_pkg::NUM_REGS; i++) begin
            arch_regs[i] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            r = lcg_next();
            u = r[31:16];
            if (i < 32) begin
                // independent CONSTs, one to each register in turn
                u.ci.opcode = lc4_pkg::OP_CONST;
                u.ci.rd     = lc4_pkg::reg_idx_t'(i % lc4_pkg::NUM_REGS);
            end else begin
                // a producer one to three words back
                src = prog[i - 1 - int'(r[11:10]) % 3];
                case (r[14:12])
                    3'd0, 3'd1: begin
                        u.rr.opcode = lc4_pkg::OP_ARITH;
                        u.rr.subop  = (r[11:10] == 2'd0) ? lc4_pkg::MUL :
                                      (r[11] ? lc4_pkg::SUB : lc4_pkg::ADD);
                    end
                    3'd2, 3'd3: begin
                        u.rr.opcode = lc4_pkg::OP_LOGIC;
                        case (r[11:10])
                            2'd0: u.rr.subop = lc4_pkg::AND;
                            2'd1: u.rr.subop = lc4_pkg::NOT;
                            2'd2: u.rr.subop = lc4_pkg::OR;
                            default: u.rr.subop = lc4_pkg::XOR;
                        endcase
                    end
                    3'd4: u.ci.opcode = lc4_pkg::OP_CONST;
                    3'd5: begin
                        // unsupported opcode, retires as a no-op
                        if (u.rr.opcode inside {lc4_pkg::OP_ARITH, lc4_pkg::OP_LOGIC,
                                                lc4_pkg::OP_CONST}) u.rr.opcode = 4'b0000;
                    end
                    3'd6: begin
                        u.rr.opcode = lc4_pkg::OP_ARITH;
                        u.rr.subop  = lc4_pkg::ADD;
                        u.rr.rs     = src.ci.rd;
                    end
                    default: begin
                        // same destination as the word before
                        src         = prog[i - 1];
                        u.rr.opcode = lc4_pkg::OP_LOGIC;
                        u.rr.subop  = lc4_pkg::XOR;
                        u.rr.rd     = src.ci.rd;
                    end
                endcase
            end
            prog[i] = u;
        end
    endtask

    task automatic retire_next(output lc4_pkg::word_t pc, output lc4_pkg::word_t insn,
                               output logic we, output lc4_pkg::reg_idx_t rd,
                               output lc4_pkg::word_t data);
        lc4_pkg::insn_u u;
        lc4_pkg::word_t a;
        lc4_pkg::word_t b;
        u    = prog[next_idx];
        a    = arch_regs[u.rr.rs];
        b    = arch_regs[u.rr.rt];
        pc   = lc4_pkg::RESET_PC + lc4_pkg::word_t'(next_idx);
        insn = u;
        rd   = u.ci.rd;
        we   = (kind_of(u) != K_NOP);
        data = '0;
        if (kind_of(u) == K_CONST) begin
            // two's complement value of imm9
            data = lc4_pkg::word_t'(int'(u.ci.imm9) - (u.ci.imm9[8] ? 512 : 0));
        end else if (we) begin
            case ({u.rr.opcode, u.rr.subop})
                {lc4_pkg::OP_ARITH, lc4_pkg::ADD}: data = a + b;
                {lc4_pkg::OP_ARITH, lc4_pkg::MUL}: data = a * b;
                {lc4_pkg::OP_ARITH, lc4_pkg::SUB}: data = a - b;
                {lc4_pkg::OP_LOGIC, lc4_pkg::AND}: data = a & b;
                {lc4_pkg::OP_LOGIC, lc4_pkg::NOT}: data = ~a;
                {lc4_pkg::OP_LOGIC, lc4_pkg::OR}:  data = a | b;
                {lc4_pkg::OP_LOGIC, lc4_pkg::XOR}: data = a ^ b;
                default: data = '0;
            endcase
        end
        if (we) arch_regs[rd] = data;
        next_idx++;
    endtask

    task automatic check_word(input string what, input lc4_pkg::word_t got,
                              input lc4_pkg::word_t exp, output bit ok);
        ok = (got === exp);
        if (!ok) $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp);
    endtask

    task automatic check_reg(input string what, input lc4_pkg::reg_idx_t got,
                             input lc4_pkg::reg_idx_t exp, output bit ok);
        ok = (got === exp);
        if (!ok) $display("[FAIL] t=%0t %s: got r%0d, expected r%0d", $time, what, got, exp);
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp,
                             output bit ok);
        ok = (got === exp);
        if (!ok) $display("[FAIL] t=%0t %s: got %b, expected %b", $time, what, got, exp);
    endtask

endmodule

//--- logic/lc4_core.sv
module lc4_core #(
    parameter lc4_pkg::word_t P_RESET_PC = lc4_pkg::RESET_PC
) (
    input  logic              gwe,
    input  logic              i_arst_n,
    input  lc4_pkg::word_t    i_insn_a,
    input  lc4_pkg::word_t    i_insn_b,
    output lc4_pkg::word_t    o_fetch_pc,
    output logic              o_wb_valid_a,
    output lc4_pkg::word_t    o_wb_pc_a,
    output lc4_pkg::word_t    o_wb_insn_a,
    output logic              o_wb_we_a,
    output lc4_pkg::reg_idx_t o_wb_rd_a,
    output lc4_pkg::word_t    o_wb_data_a,
    output logic              o_wb_valid_b,
    output lc4_pkg::word_t    o_wb_pc_b,
    output lc4_pkg::word_t    o_wb_insn_b,
    output logic              o_wb_we_b,
    output lc4_pkg::reg_idx_t o_wb_rd_b,
    output lc4_pkg::word_t    o_wb_data_b
);

    // per-pipe state, index 0 is pipe A and index 1 is pipe B
    logic [1:0]        d_valid, d_rs_re, d_rt_re, d_we;
    lc4_pkg::word_t    d_insn [2], d_pc [2], rf_rs [2], rf_rt [2];
    lc4_pkg::reg_idx_t d_rs [2], d_rt [2], d_rd [2];
    logic              issue_b;

    logic [1:0]        x_valid, x_we, x_rs_re, x_rt_re;
    lc4_pkg::word_t    x_pc [2], x_insn [2], x_rs_data [2], x_rt_data [2];
    lc4_pkg::reg_idx_t x_rs [2], x_rt [2], x_rd [2];
    lc4_pkg::word_t    byp_rs [2], byp_rt [2], alu_res [2];

    logic [1:0]        m_valid, m_we, w_valid, w_we;
    lc4_pkg::word_t    m_pc [2], m_insn [2], m_res [2];
    lc4_pkg::word_t    w_pc [2], w_insn [2], w_res [2];
    lc4_pkg::reg_idx_t m_rd [2], w_rd [2];

    lc4_issue #(.P_RESET_PC(P_RESET_PC)) u_issue (
        .gwe, .i_arst_n, .i_insn_a, .i_insn_b, .o_fetch_pc,
        .o_d_insn_a(d_insn[0]), .o_d_insn_b(d_insn[1]),
        .o_d_pc_a(d_pc[0]), .o_d_pc_b(d_pc[1]),
        .o_d_valid_a(d_valid[0]), .o_d_valid_b(d_valid[1]),
        .o_d_rs_a(d_rs[0]), .o_d_rt_a(d_rt[0]), .o_d_rd_a(d_rd[0]),
        .o_d_rs_b(d_rs[1]), .o_d_rt_b(d_rt[1]), .o_d_rd_b(d_rd[1]),
        .o_d_rs_re_a(d_rs_re[0]), .o_d_rt_re_a(d_rt_re[0]), .o_d_we_a(d_we[0]),
        .o_d_rs_re_b(d_rs_re[1]), .o_d_rt_re_b(d_rt_re[1]), .o_d_we_b(d_we[1]),
        .o_issue_b(issue_b)
    );

    // read in decode, written from the writeback registers
    lc4_regfile u_regfile (
        .gwe, .i_arst_n,
        .i_rs_a(d_rs[0]), .i_rt_a(d_rt[0]), .i_rs_b(d_rs[1]), .i_rt_b(d_rt[1]),
        .o_rs_data_a(rf_rs[0]), .o_rt_data_a(rf_rt[0]),
        .o_rs_data_b(rf_rs[1]), .o_rt_data_b(rf_rt[1]),
        .i_rd_a(w_rd[0]), .i_rd_b(w_rd[1]), .i_wdata_a(w_res[0]), .i_wdata_b(w_res[1]),
        .i_we_a(w_we[0]), .i_we_b(w_we[1])
    );

    for (genvar p = 0; p < 2; p++) begin : g_pipe
        lc4_bypass u_bypass (
            .i_x_rs(x_rs[p]), .i_x_rt(x_rt[p]),
            .i_x_rs_re(x_rs_re[p]), .i_x_rt_re(x_rt_re[p]),
            .i_rf_rs(x_rs_data[p]), .i_rf_rt(x_rt_data[p]),
            .i_m_rd_a(m_rd[0]), .i_m_rd_b(m_rd[1]), .i_w_rd_a(w_rd[0]), .i_w_rd_b(w_rd[1]),
            .i_m_we_a(m_we[0]), .i_m_we_b(m_we[1]), .i_w_we_a(w_we[0]), .i_w_we_b(w_we[1]),
            .i_m_res_a(m_res[0]), .i_m_res_b(m_res[1]),
            .i_w_res_a(w_res[0]), .i_w_res_b(w_res[1]),
            .o_rs_val(byp_rs[p]), .o_rt_val(byp_rt[p])
        );

        lc4_alu u_alu (
            .i_insn(x_insn[p]), .i_rs_val(byp_rs[p]), .i_rt_val(byp_rt[p]), .o_result(alu_res[p])
        );
    end

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            x_valid <= '0;
            x_we    <= '0;
            m_valid <= '0;
            m_we    <= '0;
            w_valid <= '0;
            w_we    <= '0;
        end else begin
            // a held-back B enters execute as a bubble
            x_valid <= {d_valid[1] & issue_b, d_valid[0]};
            x_we    <= {d_we[1] & issue_b, d_we[0]};
            m_valid <= x_valid;
            m_we    <= x_we;
            w_valid <= m_valid;
            w_we    <= m_we;
        end
    end

    always_ff @(posedge gwe) begin
        x_rs_re <= d_rs_re;
        x_rt_re <= d_rt_re;
        for (int p = 0; p < 2; p++) begin
            x_pc[p]      <= d_pc[p];
            x_insn[p]    <= d_insn[p];
            x_rs[p]      <= d_rs[p];
            x_rt[p]      <= d_rt[p];
            x_rd[p]      <= d_rd[p];
            x_rs_data[p] <= rf_rs[p];
            x_rt_data[p] <= rf_rt[p];
            // memory stage only delays the result by a cycle
            m_pc[p]      <= x_pc[p];
            m_insn[p]    <= x_insn[p];
            m_rd[p]      <= x_rd[p];
            m_res[p]     <= alu_res[p];
            w_pc[p]      <= m_pc[p];
            w_insn[p]    <= m_insn[p];
            w_rd[p]      <= m_rd[p];
            w_res[p]     <= m_res[p];
        end
    end

    assign o_wb_valid_a = w_valid[0];
    assign o_wb_pc_a    = w_pc[0];
    assign o_wb_insn_a  = w_insn[0];
    assign o_wb_we_a    = w_we[0];
    assign o_wb_rd_a    = w_rd[0];
    assign o_wb_data_a  = w_res[0];
    assign o_wb_valid_b = w_valid[1];
    assign o_wb_pc_b    = w_pc[1];
    assign o_wb_insn_b  = w_insn[1];
    assign o_wb_we_b    = w_we[1];
    assign o_wb_rd_b    = w_rd[1];
    assign o_wb_data_b  = w_res[1];

endmodule

//--- logic/lc4_alu.sv
module lc4_alu (
    input  lc4_pkg::word_t i_insn,
    input  lc4_pkg::word_t i_rs_val,
    input  lc4_pkg::word_t i_rt_val,
    output lc4_pkg::word_t o_result
);

    lc4_pkg::insn_u insn;
    lc4_pkg::word_t const_val;

    assign insn = i_insn;

    // imm9 sign extended to a full word
    assign const_val = {{7{insn.ci.imm9[8]}}, insn.ci.imm9};

    always_comb begin
        o_result = '0;
        case (insn.rr.opcode)
            lc4_pkg::OP_ARITH: begin
                case (insn.rr.subop)
                    lc4_pkg::ADD: o_result = i_rs_val + i_rt_val;
                    // only the low half of the product is kept
                    lc4_pkg::MUL: o_result = i_rs_val * i_rt_val;
                    lc4_pkg::SUB: o_result = i_rs_val - i_rt_val;
                    default:      o_result = '0;
                endcase
            end
            lc4_pkg::OP_LOGIC: begin
                case (insn.rr.subop)
                    lc4_pkg::AND: o_result = i_rs_val & i_rt_val;
                    lc4_pkg::NOT: o_result = ~i_rs_val;
                    lc4_pkg::OR:  o_result = i_rs_val | i_rt_val;
                    lc4_pkg::XOR: o_result = i_rs_val ^ i_rt_val;
                    default:      o_result = '0;
                endcase
            end
            lc4_pkg::OP_CONST: begin
                o_result = const_val;
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

//--- logic/lc4_bypass.sv
module lc4_bypass (
    input  lc4_pkg::reg_idx_t i_x_rs,
    input  lc4_pkg::reg_idx_t i_x_rt,
    input  logic              i_x_rs_re,
    input  logic              i_x_rt_re,
    input  lc4_pkg::word_t    i_rf_rs,
    input  lc4_pkg::word_t    i_rf_rt,
    input  lc4_pkg::reg_idx_t i_m_rd_a,
    input  lc4_pkg::reg_idx_t i_m_rd_b,
    input  lc4_pkg::reg_idx_t i_w_rd_a,
    input  lc4_pkg::reg_idx_t i_w_rd_b,
    input  logic              i_m_we_a,
    input  logic              i_m_we_b,
    input  logic              i_w_we_a,
    input  logic              i_w_we_b,
    input  lc4_pkg::word_t    i_m_res_a,
    input  lc4_pkg::word_t    i_m_res_b,
    input  lc4_pkg::word_t    i_w_res_a,
    input  lc4_pkg::word_t    i_w_res_b,
    output lc4_pkg::word_t    o_rs_val,
    output lc4_pkg::word_t    o_rt_val
);

    // producer matches ordered {m_b, m_a, w_b, w_a}, youngest at the top
    logic [3:0] rs_hit;
    logic [3:0] rt_hit;

    assign rs_hit = {4{i_x_rs_re}} & {i_m_we_b && (i_m_rd_b == i_x_rs),
                                      i_m_we_a && (i_m_rd_a == i_x_rs),
                                      i_w_we_b && (i_w_rd_b == i_x_rs),
                                      i_w_we_a && (i_w_rd_a == i_x_rs)};

    assign rt_hit = {4{i_x_rt_re}} & {i_m_we_b && (i_m_rd_b == i_x_rt),
                                      i_m_we_a && (i_m_rd_a == i_x_rt),
                                      i_w_we_b && (i_w_rd_b == i_x_rt),
                                      i_w_we_a && (i_w_rd_a == i_x_rt)};

    function automatic lc4_pkg::word_t pick(input logic [3:0] hit,
                                            input lc4_pkg::word_t rf_val);
        if (hit[3]) begin
            return i_m_res_b;
        end
        if (hit[2]) begin
            return i_m_res_a;
        end
        if (hit[1]) begin
            return i_w_res_b;
        end
        if (hit[0]) begin
            return i_w_res_a;
        end
        return rf_val;
    endfunction

    always_comb begin
        o_rs_val = pick(rs_hit, i_rf_rs);
        o_rt_val = pick(rt_hit, i_rf_rt);
    end

endmodule

//--- logic/lc4_issue.sv
module lc4_issue #(
    parameter lc4_pkg::word_t P_RESET_PC = lc4_pkg::RESET_PC
) (
    input  logic              gwe,
    input  logic              i_arst_n,
    input  lc4_pkg::word_t    i_insn_a,
    input  lc4_pkg::word_t    i_insn_b,
    output lc4_pkg::word_t    o_fetch_pc,
    output lc4_pkg::word_t    o_d_insn_a,
    output lc4_pkg::word_t    o_d_insn_b,
    output lc4_pkg::word_t    o_d_pc_a,
    output lc4_pkg::word_t    o_d_pc_b,
    output logic              o_d_valid_a,
    output logic              o_d_valid_b,
    output lc4_pkg::reg_idx_t o_d_rs_a,
    output lc4_pkg::reg_idx_t o_d_rt_a,
    output lc4_pkg::reg_idx_t o_d_rd_a,
    output lc4_pkg::reg_idx_t o_d_rs_b,
    output lc4_pkg::reg_idx_t o_d_rt_b,
    output lc4_pkg::reg_idx_t o_d_rd_b,
    output logic              o_d_rs_re_a,
    output logic              o_d_rt_re_a,
    output logic              o_d_we_a,
    output logic              o_d_rs_re_b,
    output logic              o_d_rt_re_b,
    output logic              o_d_we_b,
    output logic              o_issue_b
);

    lc4_pkg::word_t pc_q;
    logic           rs_re_a, rt_re_a, we_a;
    logic           rs_re_b, rt_re_b, we_b;
    logic           b_needs_a;

    lc4_decoder u_dec_a (
        .i_insn(o_d_insn_a), .o_rs(o_d_rs_a), .o_rt(o_d_rt_a), .o_rd(o_d_rd_a),
        .o_rs_re(rs_re_a), .o_rt_re(rt_re_a), .o_rd_we(we_a)
    );

    lc4_decoder u_dec_b (
        .i_insn(o_d_insn_b), .o_rs(o_d_rs_b), .o_rt(o_d_rt_b), .o_rd(o_d_rd_b),
        .o_rs_re(rs_re_b), .o_rt_re(rt_re_b), .o_rd_we(we_b)
    );

    // decode fields of an empty slot do not count
    assign o_d_rs_re_a = rs_re_a & o_d_valid_a;
    assign o_d_rt_re_a = rt_re_a & o_d_valid_a;
    assign o_d_we_a    = we_a & o_d_valid_a;
    assign o_d_rs_re_b = rs_re_b & o_d_valid_b;
    assign o_d_rt_re_b = rt_re_b & o_d_valid_b;
    assign o_d_we_b    = we_b & o_d_valid_b;

    // D-B reads the register D-A writes, so B waits and moves to pipe A
    assign b_needs_a = o_d_we_a && ((o_d_rs_re_b && (o_d_rs_b == o_d_rd_a)) ||
                                    (o_d_rt_re_b && (o_d_rt_b == o_d_rd_a)));

    assign o_issue_b  = !b_needs_a;
    assign o_fetch_pc = pc_q;

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q        <= P_RESET_PC;
            o_d_valid_a <= 1'b0;
            o_d_valid_b <= 1'b0;
        end else begin
            pc_q        <= pc_q + (b_needs_a ? 16'd1 : 16'd2);
            o_d_valid_a <= b_needs_a ? o_d_valid_b : 1'b1;
            o_d_valid_b <= 1'b1;
        end
    end

    always_ff @(posedge gwe) begin
        if (b_needs_a) begin
            // slide the pair by one word
            o_d_insn_a <= o_d_insn_b;
            o_d_pc_a   <= o_d_pc_b;
            o_d_insn_b <= i_insn_a;
            o_d_pc_b   <= pc_q;
        end else begin
            o_d_insn_a <= i_insn_a;
            o_d_pc_a   <= pc_q;
            o_d_insn_b <= i_insn_b;
            o_d_pc_b   <= pc_q + 16'd1;
        end
    end

    // the held-back word keeps its own PC in slot A and the next word follows it
    a_switch_pc: assert property (@(posedge gwe) disable iff (!i_arst_n)
        b_needs_a |=> ((o_d_pc_a == $past(o_d_pc_b)) &&
                       (o_d_pc_b == o_d_pc_a + 16'd1)));

endmodule

//--- logic/lc4_regfile.sv
module lc4_regfile (
    input  logic              gwe,
    input  logic              i_arst_n,
    input  lc4_pkg::reg_idx_t i_rs_a,
    input  lc4_pkg::reg_idx_t i_rt_a,
    input  lc4_pkg::reg_idx_t i_rs_b,
    input  lc4_pkg::reg_idx_t i_rt_b,
    output lc4_pkg::word_t    o_rs_data_a,
    output lc4_pkg::word_t    o_rt_data_a,
    output lc4_pkg::word_t    o_rs_data_b,
    output lc4_pkg::word_t    o_rt_data_b,
    input  lc4_pkg::reg_idx_t i_rd_a,
    input  lc4_pkg::reg_idx_t i_rd_b,
    input  lc4_pkg::word_t    i_wdata_a,
    input  lc4_pkg::word_t    i_wdata_b,
    input  logic              i_we_a,
    input  logic              i_we_b
);

    lc4_pkg::word_t regs [lc4_pkg::NUM_REGS];

    // a write landing this cycle shows on the read side, pipe B first
    function automatic lc4_pkg::word_t read_port(input lc4_pkg::reg_idx_t idx);
        if (i_we_b && (i_rd_b == idx)) begin
            return i_wdata_b;
        end
        if (i_we_a && (i_rd_a == idx)) begin
            return i_wdata_a;
        end
        return regs[idx];
    endfunction

    always_comb begin
        o_rs_data_a = read_port(i_rs_a);
        o_rt_data_a = read_port(i_rt_a);
        o_rs_data_b = read_port(i_rs_b);
        o_rt_data_b = read_port(i_rt_b);
    end

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < lc4_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (i_we_a) begin
                regs[i_rd_a] <= i_wdata_a;
            end
            // B is the younger write and lands last
            if (i_we_b) begin
                regs[i_rd_b] <= i_wdata_b;
            end
        end
    end

endmodule

//--- logic/lc4_decoder.sv
module lc4_decoder (
    input  lc4_pkg::word_t    i_insn,
    output lc4_pkg::reg_idx_t o_rs,
    output lc4_pkg::reg_idx_t o_rt,
    output lc4_pkg::reg_idx_t o_rd,
    output logic              o_rs_re,
    output logic              o_rt_re,
    output logic              o_rd_we
);

    lc4_pkg::insn_u insn;

    assign insn = i_insn;

    // rd sits in the same bits in both forms
    assign o_rd = insn.ci.rd;
    assign o_rs = insn.rr.rs;
    assign o_rt = insn.rr.rt;

    always_comb begin
        o_rs_re = 1'b0;
        o_rt_re = 1'b0;
        o_rd_we = 1'b0;
        case (insn.rr.opcode)
            lc4_pkg::OP_ARITH: begin
                // immediate add and divide fall through as no-ops
                if (insn.rr.subop inside {lc4_pkg::ADD, lc4_pkg::MUL, lc4_pkg::SUB}) begin
                    o_rs_re = 1'b1;
                    o_rt_re = 1'b1;
                    o_rd_we = 1'b1;
                end
            end
            lc4_pkg::OP_LOGIC: begin
                if (insn.rr.subop inside {lc4_pkg::AND, lc4_pkg::NOT, lc4_pkg::OR,
                                          lc4_pkg::XOR}) begin
                    o_rs_re = 1'b1;
                    // NOT is unary
                    o_rt_re = (insn.rr.subop != lc4_pkg::NOT);
                    o_rd_we = 1'b1;
                end
            end
            lc4_pkg::OP_CONST: begin
                o_rd_we = 1'b1;
            end
            default: begin
                o_rd_we = 1'b0;
            end
        endcase
    end

endmodule

//--- logic/lc4_pkg.sv
package lc4_pkg;

    localparam int WORD_W    = 16;
    localparam int REG_IDX_W = 3;
    localparam int NUM_REGS  = 8;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [3:0]           opcode_t;
    typedef logic [2:0]           subop_t;

    // opcodes the core executes
    localparam opcode_t OP_ARITH = 4'b0001;
    localparam opcode_t OP_LOGIC = 4'b0101;
    localparam opcode_t OP_CONST = 4'b1001;

    // insn[5:3] under OP_ARITH
    localparam subop_t ADD = 3'b000;
    localparam subop_t MUL = 3'b001;
    localparam subop_t SUB = 3'b010;

    // insn[5:3] under OP_LOGIC
    localparam subop_t AND = 3'b000;
    localparam subop_t NOT = 3'b001;
    localparam subop_t OR  = 3'b010;
    localparam subop_t XOR = 3'b011;

    // one instruction word seen as register form or constant form
    typedef union packed {
        struct packed {
            opcode_t  opcode;
            reg_idx_t rd;
            reg_idx_t rs;
            subop_t   subop;
            reg_idx_t rt;
        } rr;
        struct packed {
            opcode_t    opcode;
            reg_idx_t   rd;
            logic [8:0] imm9;
        } ci;
    } insn_u;

    localparam word_t RESET_PC = 16'h8200;

endpackage
